// ==== source/iso14443a_tx_pkg.sv ====
// iso14443a card transmit path: shared constants, vector types and bus structs
`default_nettype none

package iso14443a_tx_pkg;

    // carrier ticks in one bit period (fc/128, about 106 kbit/s)
    localparam int BIT_TICKS = 128;

    // ticks per subcarrier half period, gives fc/16 = 847.5 kHz
    localparam int SC_HALF_TICKS = 8;

    // tick position inside one bit period
    typedef logic [6:0] tick_cnt_t;

    // number of frames sent, wraps at 8 bits
    typedef logic [7:0] frame_count_t;

    // config register address
    // 0 is control, 1 clears the frame counter on any write
    typedef logic [0:0] cfg_addr_t;

    // one byte from the higher layer
    typedef struct packed {
        logic [7:0] data;
        // set on the final byte of a frame
        logic       last;
    } tx_byte_t;

    // one serialised bit handed to the frame sequencer
    typedef struct packed {
        logic data;
        // marks the data bit 7 or the parity bit, whichever ends the byte
        logic last_bit_in_byte;
    } tx_bit_t;

    // config write request
    typedef struct packed {
        cfg_addr_t  addr;
        logic [7:0] wdata;
    } cfg_write_t;

endpackage

`default_nettype wire

// ==== source/tx_config.sv ====
// transmit config registers: parity and transmit enables plus a sent frame counter
`default_nettype none
`timescale 1ns/10ps

module tx_config (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire                                 cfg_valid,
    input  wire iso14443a_tx_pkg::cfg_write_t   cfg_wr,
    input  wire                                 tx_busy,
    input  wire                                 frame_done,
    output logic                                cfg_ready,
    output logic                                parity_en,
    output logic                                tx_en,
    output iso14443a_tx_pkg::frame_count_t      frame_count
);

    // register map
    localparam iso14443a_tx_pkg::cfg_addr_t ADDR_CTRL  = 1'b0;
    localparam iso14443a_tx_pkg::cfg_addr_t ADDR_CLEAR = 1'b1;

    // control register bit positions
    localparam int CTRL_TX_EN  = 0;
    localparam int CTRL_PARITY = 1;

    logic wr_fire;

    // hold off writes for the whole frame so the controls stay stable
    assign cfg_ready = !tx_busy;
    assign wr_fire   = cfg_valid && cfg_ready;

    // control bits, written on the handshake edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            parity_en <= 1'b1;
            tx_en     <= 1'b0;
        end else if (wr_fire && (cfg_wr.addr == ADDR_CTRL)) begin
            parity_en <= cfg_wr.wdata[CTRL_PARITY];
            tx_en     <= cfg_wr.wdata[CTRL_TX_EN];
        end
    end

    // frame counter
    // a clear wins over a frame_done in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame_count <= '0;
        end else if (wr_fire && (cfg_wr.addr == ADDR_CLEAR)) begin
            frame_count <= '0;
        end else if (frame_done) begin
            // wraps naturally at 8 bits
            frame_count <= frame_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== source/byte_serialiser.sv ====
// byte to bit serialiser: lsb first with optional odd parity after each byte
`default_nettype none
`timescale 1ns/10ps

module byte_serialiser (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire                                 parity_en,
    input  wire                                 tx_en,
    input  wire                                 byte_valid,
    input  wire iso14443a_tx_pkg::tx_byte_t     byte_in,
    input  wire                                 bit_req,
    output logic                                byte_ready,
    output logic                                bit_valid,
    output iso14443a_tx_pkg::tx_bit_t           bit_out
);

    // one byte holding register in front of the shifter
    iso14443a_tx_pkg::tx_byte_t buf_q;
    logic                       buf_full;

    // byte currently being shifted out
    iso14443a_tx_pkg::tx_byte_t cur_q;
    // 0..7 data bits, 8 the parity bit
    logic [3:0]                 bit_idx;
    // running odd parity over the bits sent so far
    logic                       par_q;

    logic accept;
    logic take;
    logic byte_end;

    assign byte_ready = !buf_full && tx_en;
    assign accept     = byte_valid && byte_ready;

    // current bit is the final one of its byte
    assign byte_end = parity_en ? (bit_idx == 4'd8) : (bit_idx == 4'd7);

    // move the buffered byte into the shifter
    // either to start a frame, or on the req that ends a non-last byte
    assign take = buf_full && (!bit_valid || (bit_req && byte_end && !cur_q.last));

    // bit presented to tx
    always_comb begin
        bit_out.data             = (bit_idx == 4'd8) ? par_q : cur_q.data[bit_idx[2:0]];
        bit_out.last_bit_in_byte = byte_end;
    end

    // holding register flag
    // accept only happens while empty and take only while full, so they never clash
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            buf_full <= 1'b0;
        end else if (accept) begin
            buf_full <= 1'b1;
        end else if (take) begin
            buf_full <= 1'b0;
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (accept) begin
            buf_q <= byte_in;
        end
        if (take) begin
            cur_q <= buf_q;
        end
    end

    // shifter control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_valid <= 1'b0;
            bit_idx   <= '0;
            par_q     <= 1'b1;
        end else if (take) begin
            // first bit of a fresh byte, parity restarts at 1 for odd
            bit_valid <= 1'b1;
            bit_idx   <= '0;
            par_q     <= 1'b1;
        end else if (bit_req && bit_valid) begin
            if (byte_end) begin
                // end of frame, or the sender fell behind
                bit_valid <= 1'b0;
            end else begin
                bit_idx <= bit_idx + 4'd1;
                par_q   <= par_q ^ cur_q.data[bit_idx[2:0]];
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/bit_encoder.sv ====
// manchester bit encoder: one bit per bit period, level then its inverse
`default_nettype none
`timescale 1ns/10ps

module bit_encoder #(
    parameter int BIT_TICKS = iso14443a_tx_pkg::BIT_TICKS
) (
    input  wire     clk,
    input  wire     rst_n,
    input  wire     en,
    input  wire     bit_data,
    input  wire     bit_valid,
    output logic    encoded_data,
    output logic    tick_req,
    output logic    last_tick
);

    localparam iso14443a_tx_pkg::tick_cnt_t LAST_CNT = iso14443a_tx_pkg::tick_cnt_t'(BIT_TICKS - 1);
    localparam iso14443a_tx_pkg::tick_cnt_t REQ_CNT  = iso14443a_tx_pkg::tick_cnt_t'(BIT_TICKS - 2);
    localparam iso14443a_tx_pkg::tick_cnt_t HALF_CNT = iso14443a_tx_pkg::tick_cnt_t'(BIT_TICKS / 2);

    iso14443a_tx_pkg::tick_cnt_t tick_cnt;
    logic                        bit_q;
    logic                        cur_bit;

    // tick counter, parked at 0 while disabled
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tick_cnt <= '0;
        end else if (!en) begin
            tick_cnt <= '0;
        end else if (tick_cnt == LAST_CNT) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    // capture the bit at the start of its period
    always_ff @(posedge clk) begin
        if (en && bit_valid && (tick_cnt == '0)) begin
            bit_q <= bit_data;
        end
    end

    // on tick 0 the input is used directly, later ticks use the captured copy
    assign cur_bit = (tick_cnt == '0) ? bit_data : bit_q;

    // first half carries the bit, second half its inverse
    assign encoded_data = en && ((tick_cnt < HALF_CNT) ? cur_bit : !cur_bit);

    // ask for the next bit one tick early so it is ready by tick 0
    assign tick_req  = en && bit_valid && (tick_cnt == REQ_CNT);
    assign last_tick = en && (tick_cnt == LAST_CNT);

endmodule

`default_nettype wire

// ==== source/subcarrier.sv ====
// subcarrier generator: fc/16 square wave, phase restarted on every enable
`default_nettype none
`timescale 1ns/10ps

module subcarrier (
    input  wire     clk,
    input  wire     rst_n,
    input  wire     en,
    output logic    subcarrier
);

    localparam int CNT_W = $clog2(iso14443a_tx_pkg::SC_HALF_TICKS);
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(iso14443a_tx_pkg::SC_HALF_TICKS - 1);

    logic [CNT_W-1:0] div_cnt;

    // output low and divider cleared while off, so each frame starts in phase
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt    <= '0;
            subcarrier <= 1'b0;
        end else if (!en) begin
            div_cnt    <= '0;
            subcarrier <= 1'b0;
        end else if (div_cnt == HALF_LAST) begin
            div_cnt    <= '0;
            subcarrier <= !subcarrier;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== source/tx.sv ====
// frame sequencer: start bit then data bits, manchester encoded onto the subcarrier
`default_nettype none
`timescale 1ns/10ps

module tx #(
    parameter int BIT_TICKS = iso14443a_tx_pkg::BIT_TICKS
) (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire                             bit_valid,
    input  wire iso14443a_tx_pkg::tx_bit_t  bit_in,
    output logic                            bit_req,
    output logic                            tx_busy,
    output logic                            frame_done,
    output logic                            tx_out
);

    typedef enum logic [1:0] {
        s_idle,
        s_start,
        s_data
    } state_t;

    state_t state;

    // encoder and subcarrier signals
    logic en;
    logic be_data;
    logic be_valid;
    logic be_tick_req;
    logic be_last_tick;
    logic encoded_data;
    logic sc;

    // frame sequencing
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= s_idle;
            frame_done <= 1'b0;
        end else begin
            // single cycle pulse
            frame_done <= 1'b0;

            case (state)
                s_idle: begin
                    // a valid bit means a frame is waiting
                    if (bit_valid) begin
                        state <= s_start;
                    end
                end

                s_start: begin
                    // start bit period nearly over, first data bit is already waiting
                    if (be_tick_req) begin
                        state <= s_data;
                    end
                end

                s_data: begin
                    // nothing left after this bit, unmodulated end of frame
                    if (be_last_tick && !bit_valid) begin
                        state      <= s_idle;
                        frame_done <= 1'b1;
                    end
                end

                default: begin
                    state <= s_idle;
                end
            endcase
        end
    end

    assign en      = (state != s_idle);
    assign tx_busy = en;

    // start of communication is a logic 1
    assign be_data  = (state == s_start) ? 1'b1 : bit_in.data;
    assign be_valid = (state == s_start) || ((state == s_data) && bit_valid);

    // during data the encoder's request consumes the current bit upstream
    // the start bit is generated here, so no request goes out for it
    assign bit_req = (state == s_data) && be_tick_req;

    subcarrier sc_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .en         (en),
        .subcarrier (sc)
    );

    bit_encoder #(
        .BIT_TICKS (BIT_TICKS)
    ) enc_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .en           (en),
        .bit_data     (be_data),
        .bit_valid    (be_valid),
        .encoded_data (encoded_data),
        .tick_req     (be_tick_req),
        .last_tick    (be_last_tick)
    );

    // registered so no glitch from the AND reaches the load modulator
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_out <= 1'b0;
        end else begin
            tx_out <= sc & encoded_data;
        end
    end

endmodule

`default_nettype wire

// ==== source/pcd_tx_top.sv ====
// card transmit top: config registers, byte serialiser and frame sequencer
`default_nettype none
`timescale 1ns/10ps

module pcd_tx_top #(
    parameter int BIT_TICKS = iso14443a_tx_pkg::BIT_TICKS
) (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire                                 cfg_valid,
    input  wire iso14443a_tx_pkg::cfg_write_t   cfg_wr,
    input  wire                                 byte_valid,
    input  wire iso14443a_tx_pkg::tx_byte_t     byte_in,
    output logic                                cfg_ready,
    output iso14443a_tx_pkg::frame_count_t      frame_count,
    output logic                                byte_ready,
    output logic                                tx_out
);

    // controls from the config block
    logic parity_en;
    logic tx_en;

    // status back from the sequencer
    logic tx_busy;
    logic frame_done;

    // bit handshake between serialiser and sequencer
    logic                      bit_valid;
    logic                      bit_req;
    iso14443a_tx_pkg::tx_bit_t bit_out;

    tx_config cfg_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg_valid   (cfg_valid),
        .cfg_wr      (cfg_wr),
        .tx_busy     (tx_busy),
        .frame_done  (frame_done),
        .cfg_ready   (cfg_ready),
        .parity_en   (parity_en),
        .tx_en       (tx_en),
        .frame_count (frame_count)
    );

    byte_serialiser ser_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .parity_en  (parity_en),
        .tx_en      (tx_en),
        .byte_valid (byte_valid),
        .byte_in    (byte_in),
        .bit_req    (bit_req),
        .byte_ready (byte_ready),
        .bit_valid  (bit_valid),
        .bit_out    (bit_out)
    );

    tx #(
        .BIT_TICKS (BIT_TICKS)
    ) tx_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .bit_valid  (bit_valid),
        .bit_in     (bit_out),
        .bit_req    (bit_req),
        .tx_busy    (tx_busy),
        .frame_done (frame_done),
        .tx_out     (tx_out)
    );

endmodule

`default_nettype wire

// ==== verification/tb_clock.sv ====
// testbench clock and reset generator: free running clock, active low reset at start
`default_nettype none
`timescale 1ns/10ps

module tb_clock #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

    // release on a falling edge, away from the rising edge that samples it
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== verification/tb_pcd_tx.sv ====
// card transmit path testbench that sends frames, decodes tx_out and checks bits and counters
`default_nettype none
`timescale 1ns/10ps

module tb_pcd_tx;

    localparam int HALF_TICKS = iso14443a_tx_pkg::BIT_TICKS / 2;
    // subcarrier pulses in one modulated half bit
    localparam int PULSES = HALF_TICKS / (2 * iso14443a_tx_pkg::SC_HALF_TICKS);
    localparam logic [31:0] SEED = 32'hd0bfe819;
    localparam int NUM_TESTS   = 6;
    localparam int WRAP_FRAMES = 256;
    localparam int T6_FRAMES   = 3;
    // register map of the config block
    localparam iso14443a_tx_pkg::cfg_addr_t ADDR_CTRL  = 1'b0;
    localparam iso14443a_tx_pkg::cfg_addr_t ADDR_CLEAR = 1'b1;
    localparam logic [7:0] CTRL_TX_EN  = 8'h01;
    localparam logic [7:0] CTRL_PARITY = 8'h02;

    logic                              clk;
    logic                              rst_n;
    logic                              cfg_valid;
    iso14443a_tx_pkg::cfg_write_t      cfg_wr;
    logic                              byte_valid;
    iso14443a_tx_pkg::tx_byte_t        byte_in;
    logic                              cfg_ready;
    iso14443a_tx_pkg::frame_count_t    frame_count;
    logic                              byte_ready;
    logic                              tx_out;

    // reference model state
    logic                              exp_bits[$];
    int                                exp_len[$];
    // bytes of the frame planned last
    logic [7:0]                        frame_bytes[$];
    logic                              model_parity = 1'b1;
    iso14443a_tx_pkg::frame_count_t    model_count = '0;
    logic [31:0]                       rng = SEED;
    logic                              prev_out = 1'b0;
    int                                frames_sent = 0;
    int                                frames_decoded = 0;
    int                                errors = 0;
    int                                checks = 0;

    tb_clock #(.PERIOD_NS(20), .RESET_CYCLES(8)) clk_i (.clk(clk), .rst_n(rst_n));

    pcd_tx_top #(
        .BIT_TICKS (iso14443a_tx_pkg::BIT_TICKS)
    ) pcd_tx_top_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg_valid   (cfg_valid),
        .cfg_wr      (cfg_wr),
        .byte_valid  (byte_valid),
        .byte_in     (byte_in),
        .cfg_ready   (cfg_ready),
        .frame_count (frame_count),
        .byte_ready  (byte_ready),
        .tx_out      (tx_out)
    );

    // counter only steps by one or clears
    count_step: assert property (@(negedge clk) disable iff (!rst_n)
        (frame_count == $past(frame_count)) || (frame_count == 8'd0) ||
        (frame_count == $past(frame_count) + 8'd1))
    else begin
        errors++;
        $display("frame_count jumped by more than one step at %0t", $time);
    end

    // a frame ends in idle and the counter never moves while busy
    count_idle: assert property (@(negedge clk) disable iff (!rst_n)
        (frame_count != $past(frame_count)) |-> cfg_ready)
    else begin
        errors++;
        $display("frame_count changed while a frame was in progress at %0t", $time);
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // longest frame with parity in clock cycles
    function automatic int frame_budget(input int nbytes);
        return (1 + 9 * nbytes) * iso14443a_tx_pkg::BIT_TICKS;
    endfunction

    task automatic write_cfg(input iso14443a_tx_pkg::cfg_addr_t addr, input logic [7:0] wdata,
                             output int held);
        held = 0;
        @(negedge clk);
        cfg_wr.addr  = addr;
        cfg_wr.wdata = wdata;
        cfg_valid    = 1'b1;
        while (!cfg_ready) begin
            held++;
            @(negedge clk);
        end
        @(negedge clk);
        cfg_valid = 1'b0;
    endtask

    // byte_ready seen high on this falling edge means the next rising edge transfers
    task automatic send_byte(input logic [7:0] data, input logic last);
        @(negedge clk);
        byte_in.data = data;
        byte_in.last = last;
        byte_valid   = 1'b1;
        while (!byte_ready) begin
            @(negedge clk);
        end
        @(negedge clk);
        byte_valid = 1'b0;
    endtask

    // random bytes of one frame and the bit stream they must produce
    task automatic plan_frame(input int nbytes);
        logic [31:0] rnd;
        int          i;
        int          b;
        frame_bytes.delete();
        for (i = 0; i < nbytes; i++) begin
            rnd = next_rand();
            frame_bytes.push_back(rnd[7:0]);
        end
        exp_len.push_back(1 + nbytes * (model_parity ? 9 : 8));
        // start of communication
        exp_bits.push_back(1'b1);
        for (i = 0; i < nbytes; i++) begin
            for (b = 0; b < 8; b++) begin
                exp_bits.push_back(frame_bytes[i][b]);
            end
            // odd parity over the byte
            if (model_parity) begin
                exp_bits.push_back(~^frame_bytes[i]);
            end
        end
    endtask

    // expected bits queued before the first byte goes out
    task automatic send_frame(input int nbytes);
        int i;
        plan_frame(nbytes);
        for (i = 0; i < nbytes; i++) begin
            send_byte(frame_bytes[i], i == nbytes - 1);
        end
    endtask

    task automatic check_count();
        checks++;
        assert (frame_count == model_count) else begin
            errors++;
            $display("ERR %0t frame_count got %0d expected %0d", $time, frame_count, model_count);
        end
    endtask

    // wait for the decoder to finish the frame and count it
    task automatic finish_frame();
        frames_sent++;
        while (frames_decoded < frames_sent) begin
            @(negedge clk);
        end
        model_count = model_count + 8'd1;
        check_count();
    endtask

    task automatic run_frame(input int nbytes);
        send_frame(nbytes);
        finish_frame();
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        $display("test %0d %s: %s, %0d errors", num, name,
                 (errors == errs_before) ? "ok" : "failed", errors - errs_before);
    endtask

    // rising edges of tx_out over one half bit sampled on falling edges
    task automatic count_window(output int pulses);
        int i;
        pulses = 0;
        for (i = 0; i < HALF_TICKS; i++) begin
            if (tx_out && !prev_out) begin
                pulses++;
            end
            prev_out = tx_out;
            @(negedge clk);
        end
    endtask

    // pulses start mid subcarrier period
    // windows aligned to the first edge cover whole half bits
    initial begin : decoder
        int   first_cnt;
        int   second_cnt;
        int   nbits;
        int   len_exp;
        logic bit_got;
        logic bit_exp;
        logic in_frame;
        @(posedge rst_n);
        forever begin
            @(negedge clk);
            while (tx_out !== 1'b1) begin
                @(negedge clk);
            end
            prev_out = 1'b0;
            nbits    = 0;
            in_frame = 1'b1;
            if (exp_len.size() > 0) begin
                len_exp = exp_len.pop_front();
            end else begin
                len_exp = 0;
                errors++;
                $display("frame seen on tx_out at %0t with no frame sent", $time);
            end
            while (in_frame) begin
                count_window(first_cnt);
                count_window(second_cnt);
                // a silent bit period is the end of frame
                if ((first_cnt == 0) && (second_cnt == 0)) begin
                    in_frame = 1'b0;
                end else begin
                    bit_got = (first_cnt != 0);
                    checks++;
                    assert (((first_cnt == PULSES) && (second_cnt == 0)) ||
                            ((first_cnt == 0) && (second_cnt == PULSES))) else begin
                        errors++;
                        $display("ERR %0t tx_out pulses bit %0d got %0d/%0d expected %0d",
                                 $time, nbits, first_cnt, second_cnt, PULSES);
                    end
                    if (nbits < len_exp) begin
                        bit_exp = exp_bits.pop_front();
                        checks++;
                        assert (bit_got == bit_exp) else begin
                            errors++;
                            $display("ERR %0t tx_out bit %0d of frame %0d got %0b expected %0b",
                                     $time, nbits, frames_decoded, bit_got, bit_exp);
                        end
                    end
                    nbits++;
                end
            end
            checks++;
            assert (nbits == len_exp) else begin
                errors++;
                $display("ERR %0t tx_out frame length got %0d bits expected %0d",
                         $time, nbits, len_exp);
            end
            // keep the queue aligned after a short frame
            while (nbits < len_exp) begin
                bit_exp = exp_bits.pop_front();
                nbits++;
            end
            frames_decoded++;
        end
    end

    initial begin : watchdog
        int cycles;
        int limit;
        cycles = 0;
        // frames of every test at full parity length plus a fifth
        limit = frame_budget(1) + frame_budget(4) + frame_budget(2) + frame_budget(1) +
                (WRAP_FRAMES + 1) * frame_budget(1) + T6_FRAMES * frame_budget(2);
        limit = limit * 6 / 5;
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the tests did not finish within %0d cycles", limit);
        $display("TEST FAIL");
        $finish;
    end

    initial begin : stimulus
        int          errs;
        int          held;
        int          k;
        logic [31:0] rnd;
        cfg_valid  = 1'b0;
        cfg_wr     = '0;
        byte_valid = 1'b0;
        byte_in    = '0;
        @(posedge rst_n);

        // a byte offered before the enable waits while the outputs stay quiet
        errs = errors;
        plan_frame(1);
        fork
            send_byte(frame_bytes[0], 1'b1);
            begin
                repeat (40) begin
                    @(negedge clk);
                    checks++;
                    assert (!tx_out && !byte_ready && cfg_ready) else begin
                        errors++;
                        $display("ERR %0t tx_out,byte_ready,cfg_ready got %0b%0b%0b expected 001",
                                 $time, tx_out, byte_ready, cfg_ready);
                    end
                end
                write_cfg(ADDR_CTRL, CTRL_TX_EN | CTRL_PARITY, held);
                model_parity = 1'b1;
                checks++;
                assert (byte_ready) else begin
                    errors++;
                    $display("ERR %0t byte_ready got %0b expected 1", $time, byte_ready);
                end
            end
        join
        report_test(1, "idle after reset", errs);

        // the waiting byte goes out as soon as transmit is enabled
        errs = errors;
        finish_frame();
        report_test(2, "single byte with parity", errs);

        errs = errors;
        write_cfg(ADDR_CTRL, CTRL_TX_EN, held);
        model_parity = 1'b0;
        rnd = next_rand();
        run_frame(2 + int'(rnd % 32'd3));
        report_test(3, "multi byte without parity", errs);

        // parity switched on while a frame without parity is on air
        errs = errors;
        fork
            send_frame(2);
            begin
                while (cfg_ready) begin
                    @(negedge clk);
                end
                write_cfg(ADDR_CTRL, CTRL_TX_EN | CTRL_PARITY, held);
                model_parity = 1'b1;
            end
        join
        finish_frame();
        checks++;
        assert (held > 0) else begin
            errors++;
            $display("ERR %0t cfg_ready held cycles got %0d expected above 0", $time, held);
        end
        run_frame(1);
        report_test(4, "config write held off", errs);

        errs = errors;
        write_cfg(ADDR_CLEAR, 8'h00, held);
        model_count = '0;
        check_count();
        write_cfg(ADDR_CTRL, CTRL_TX_EN, held);
        model_parity = 1'b0;
        for (k = 0; k < WRAP_FRAMES; k++) begin
            run_frame(1);
        end
        checks++;
        assert (frame_count == 8'd0) else begin
            errors++;
            $display("ERR %0t frame_count after wrap got %0d expected 0", $time, frame_count);
        end
        run_frame(1);
        write_cfg(ADDR_CLEAR, 8'h00, held);
        model_count = '0;
        check_count();
        report_test(5, "frame counter wrap and clear", errs);

        // idle gaps of random length before each frame
        errs = errors;
        write_cfg(ADDR_CTRL, CTRL_TX_EN | CTRL_PARITY, held);
        model_parity = 1'b1;
        for (k = 0; k < T6_FRAMES; k++) begin
            rnd = next_rand();
            repeat (1 + int'(rnd % 32'd64)) @(negedge clk);
            run_frame(1 + int'((rnd >> 8) % 32'd2));
        end
        report_test(6, "delayed frames", errs);

        $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
source/iso14443a_tx_pkg.sv
source/tx_config.sv
source/byte_serialiser.sv
source/bit_encoder.sv
source/subcarrier.sv
source/tx.sv
source/pcd_tx_top.sv
verification/tb_clock.sv
verification/tb_pcd_tx.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the card transmit path testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_pcd_tx \
    -f src.f \
    --Mdir obj_dir -o sim_pcd_tx

./obj_dir/sim_pcd_tx > sim.log 2>&1
cat sim.log

# the testbench prints the fail message on any failed check or timeout
if grep -q "TEST FAIL" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi

echo "simulation passed"
